// File: Makefile
# Verilator build and run for the router output port testbench.

VERILATOR ?= verilator
TOP       ?= routerOutputPortTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/arbConfig.sv
`timescale 1ns/1ps
`include "routerConsts.svh"

module arbConfig (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cfgWrite,
  input  routerPkg::cfgAddr          cfgAddr,
  input  logic [`LEN_W-1:0]          cfgData,
  output logic [`ROUTER_PORTS-1:0]   portEnable,
  output logic [`LEN_W-1:0]          holdCap
);

  import routerPkg::*;

  // a write lands at the strobe edge and the arbiter sees it next cycle.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      portEnable <= `RST_MASK;
      holdCap <= `RST_CAP;
    end
    else if (cfgWrite)
    begin
      case (cfgAddr)
        ADDR_MASK:
        begin
          portEnable <= cfgData[`ROUTER_PORTS-1:0];
        end
        ADDR_CAP:
        begin
          holdCap <= cfgData;
        end
        default:
        begin
          // unmapped addresses are dropped.
          portEnable <= portEnable;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~

  // the strobe has no handshake, so the address must be settled with it.
  cfgAddrKnown: assert property (
    @(posedge clk) disable iff (rst)
    cfgWrite |-> !$isunknown(cfgAddr)
  );

endmodule

// File: logic/grantTimer.sv
`timescale 1ns/1ps
`include "routerConsts.svh"

module grantTimer (
  input  logic               clk,
  input  logic               rst,
  input  logic [`ID_W-1:0]   flitId,
  input  logic [`LEN_W-1:0]  pktLength,
  input  logic [`LEN_W-1:0]  holdCap,
  input  logic               run,
  output logic               timesUp
);

  logic [`LEN_W-1:0] latchedLen;
  logic [`LEN_W-1:0] count;
  logic [`LEN_W-1:0] limit;

  // the packet length only bounds the hold up to the configured cap.
  assign limit = (latchedLen < holdCap) ? latchedLen : holdCap;
  assign timesUp = (count == limit);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      latchedLen <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == `HEAD_ID)
        latchedLen <= pktLength;
      // count only runs while the port keeps its grant.
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // the arbiter must drop run once the limit is reached.
  countInRange: assert property (
    @(posedge clk) disable iff (rst)
    run |-> count <= limit
  );

endmodule

// File: logic/outputArbiter.sv
`timescale 1ns/1ps
`include "routerConsts.svh"

module outputArbiter (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [`ROUTER_PORTS-1:0]             req,
  input  logic [`ROUTER_PORTS-1:0][`ID_W-1:0]  flitId,
  input  logic [`ROUTER_PORTS-1:0][`LEN_W-1:0] pktLength,
  input  logic [`ROUTER_PORTS-1:0]             portEnable,
  input  logic [`LEN_W-1:0]                    holdCap,
  output routerPkg::grantState                 grant
);

  import routerPkg::*;

  grantState nextGrant;
  logic [`ROUTER_PORTS-1:0] active;
  logic [`ROUTER_PORTS-1:0] run;
  logic [`ROUTER_PORTS-1:0] timesUp;
  logic [2:0] holder;

  // a disabled port counts as not requesting.
  assign active = req & portEnable;
  assign holder = grant - 3'd1;

  // ~~~~~~~~~~~~~~~~~~~~
  // hold timers
  // ~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < `ROUTER_PORTS; p++)
  begin : gTimer
    grantTimer uTimer (
      .clk       (clk),
      .rst       (rst),
      .flitId    (flitId[p]),
      .pktLength (pktLength[p]),
      .holdCap   (holdCap),
      .run       (run[p]),
      .timesUp   (timesUp[p])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // grant state machine
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    int idx;
    nextGrant = IDLE;
    run = '0;
    idx = 0;
    if (grant == IDLE)
    begin
      // fixed priority L, N, E, W, S out of idle.
      for (int i = `ROUTER_PORTS - 1; i >= 0; i--)
      begin
        if (active[i])
          nextGrant = grantState'(3'(i + 1));
      end
    end
    else if (grant <= GNT_S)
    begin
      if (active[holder] && !timesUp[holder])
      begin
        nextGrant = grant;
        run[holder] = 1'b1;
      end
      else
      begin
        // search the others in cyclic order after the holder.
        // walking from the far end lets the nearest requester win.
        for (int k = `ROUTER_PORTS - 1; k >= 1; k--)
        begin
          idx = int'(holder) + k;
          if (idx >= `ROUTER_PORTS)
            idx = idx - `ROUTER_PORTS;
          if (active[idx])
            nextGrant = grantState'(3'(idx + 1));
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= IDLE;
    else
      grant <= nextGrant;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~

  grantLegal: assert property (
    @(posedge clk) disable iff (rst)
    grant inside {IDLE, GNT_L, GNT_N, GNT_E, GNT_W, GNT_S}
  );

  // a fresh grant must go to a port that was enabled in the deciding cycle.
  grantWasEnabled: assert property (
    @(posedge clk) disable iff (rst)
    (grant != IDLE && grant != $past(grant))
      |-> |($past(portEnable) & (`ROUTER_PORTS'(1) << holder))
  );

endmodule

// File: logic/outputMux.sv
`timescale 1ns/1ps
`include "routerConsts.svh"

module outputMux (
  input  logic                                  clk,
  input  logic                                  rst,
  input  routerPkg::grantState                  grant,
  input  logic [`ROUTER_PORTS-1:0]              req,
  input  logic [`ROUTER_PORTS-1:0][`FLIT_W-1:0] flitData,
  output logic                                  outValid,
  output logic [`FLIT_W-1:0]                    outData
);

  import routerPkg::*;

  logic [2:0] sel;
  logic hit;

  assign sel = grant - 3'd1;
  // the holder only forwards a word in cycles where it still requests.
  assign hit = (grant != IDLE) && (grant <= GNT_S) && req[sel];

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= hit;
  end

  always_ff @(posedge clk)
  begin
    if (hit)
      outData <= flitData[sel];
  end

  // an idle output port must not present a flit on the next cycle.
  idleNoValid: assert property (
    @(posedge clk) disable iff (rst)
    $past(grant) == IDLE |-> !outValid
  );

endmodule

// File: logic/routerConsts.svh
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// port and datapath sizes
// ~~~~~~~~~~~~~~~~~~~~

// inputs are indexed L=0, N=1, E=2, W=3, S=4.
`define ROUTER_PORTS 5
`define FLIT_W 32
`define LEN_W 12
`define ID_W 3

// flit id that marks the first flit of a packet.
`define HEAD_ID 3'd1

`define CFG_ADDR_W 2

// ~~~~~~~~~~~~~~~~~~~~
// configuration reset values
// ~~~~~~~~~~~~~~~~~~~~

`define RST_MASK {`ROUTER_PORTS{1'b1}}
`define RST_CAP {`LEN_W{1'b1}}

`endif

// File: logic/routerOutputPort.sv
`timescale 1ns/1ps
`include "routerConsts.svh"

module routerOutputPort (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`ROUTER_PORTS-1:0]              req,
  input  logic [`ROUTER_PORTS-1:0][`ID_W-1:0]   flitId,
  input  logic [`ROUTER_PORTS-1:0][`LEN_W-1:0]  pktLength,
  input  logic [`ROUTER_PORTS-1:0][`FLIT_W-1:0] flitData,
  input  logic                                  cfgWrite,
  input  routerPkg::cfgAddr                     cfgAddr,
  input  logic [`LEN_W-1:0]                     cfgData,
  output routerPkg::grantState                  grant,
  output logic                                  outValid,
  output logic [`FLIT_W-1:0]                    outData
);

  logic [`ROUTER_PORTS-1:0] portEnable;
  logic [`LEN_W-1:0] holdCap;

  arbConfig uArbConfig (
    .clk        (clk),
    .rst        (rst),
    .cfgWrite   (cfgWrite),
    .cfgAddr    (cfgAddr),
    .cfgData    (cfgData),
    .portEnable (portEnable),
    .holdCap    (holdCap)
  );

  // the grant feeds the mux and is also visible at the port boundary.
  outputArbiter uOutputArbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .flitId     (flitId),
    .pktLength  (pktLength),
    .portEnable (portEnable),
    .holdCap    (holdCap),
    .grant      (grant)
  );

  outputMux uOutputMux (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .req      (req),
    .flitData (flitData),
    .outValid (outValid),
    .outData  (outData)
  );

endmodule

// File: logic/routerPkg.sv
package routerPkg;

  // grant state of the output port, one state per input plus idle.
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    GNT_L = 3'd1,
    GNT_N = 3'd2,
    GNT_E = 3'd3,
    GNT_W = 3'd4,
    GNT_S = 3'd5
  } grantState;

  // flit id encodings carried next to each flit.
  typedef enum logic [2:0] {
    BODY = 3'd0,
    HEAD = 3'd1,
    TAIL = 3'd2
  } flitKind;

  // register map of the arbiter configuration block.
  typedef enum logic [1:0] {
    ADDR_MASK = 2'd0,
    ADDR_CAP  = 2'd1
  } cfgAddr;

endpackage

// File: sim/routerOutputPortTb.sv
`timescale 1ns/1ps
`include "routerConsts.svh"

module routerOutputPortTb;

  import routerPkg::*;

  localparam int NUM_TESTS = 7;
  localparam int RESET_CYCLES = 8;

  logic clk;
  logic rst;
  logic [`ROUTER_PORTS-1:0] req;
  logic [`ROUTER_PORTS-1:0][`ID_W-1:0] flitId;
  logic [`ROUTER_PORTS-1:0][`LEN_W-1:0] pktLength;
  logic [`ROUTER_PORTS-1:0][`FLIT_W-1:0] flitData;
  logic cfgWrite;
  cfgAddr cfgSel;
  logic [`LEN_W-1:0] cfgData;
  grantState grant;
  logic outValid;
  logic [`FLIT_W-1:0] outData;

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~

  string testName [NUM_TESTS];
  logic [`ROUTER_PORTS-1:0] testMask [NUM_TESTS];
  logic [`LEN_W-1:0] testCap [NUM_TESTS];
  logic [`ROUTER_PORTS-1:0] testReq [NUM_TESTS];
  logic [`ROUTER_PORTS-1:0][`LEN_W-1:0] testLen [NUM_TESTS];
  int testCycles [NUM_TESTS];
  int tableSize;

  // reference model state, updated at every rising edge.
  logic [2:0] expGrant;
  logic [`ROUTER_PORTS-1:0] refMask;
  logic [`LEN_W-1:0] refCap;
  logic [`LEN_W-1:0] refLen [`ROUTER_PORTS];
  logic [`LEN_W-1:0] refCount [`ROUTER_PORTS];
  logic expValid;
  logic [`FLIT_W-1:0] expData;

  logic [31:0] lcgState;
  string currentTest;
  int cycleCount;
  int cycleLimit;

  routerOutputPort uut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .flitId    (flitId),
    .pktLength (pktLength),
    .flitData  (flitData),
    .cfgWrite  (cfgWrite),
    .cfgAddr   (cfgSel),
    .cfgData   (cfgData),
    .grant     (grant),
    .outValid  (outValid),
    .outData   (outData)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic addTest(input string name, input logic [`ROUTER_PORTS-1:0] mask,
                         input logic [`LEN_W-1:0] cap, input logic [`ROUTER_PORTS-1:0] reqBits,
                         input logic [`ROUTER_PORTS-1:0][`LEN_W-1:0] lens, input int cycles);
    testName[tableSize] = name;
    testMask[tableSize] = mask;
    testCap[tableSize] = cap;
    testReq[tableSize] = reqBits;
    testLen[tableSize] = lens;
    testCycles[tableSize] = cycles;
    tableSize++;
  endtask

  task automatic endRun();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  // the hold limit is the latched length clipped by the cap.
  function automatic logic [`LEN_W-1:0] limitOf(input int p);
    return (refLen[p] < refCap) ? refLen[p] : refCap;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic modelStep();
    logic [`ROUTER_PORTS-1:0] active;
    logic [2:0] nextGrant;
    logic hold;
    int holder;
    int idx;
    active = req & refMask;
    holder = int'(expGrant) - 1;
    nextGrant = 3'd0;
    hold = 1'b0;
    if (rst)
    begin
      expGrant = 3'd0;
      expValid = 1'b0;
      refMask = `RST_MASK;
      refCap = `RST_CAP;
      for (int p = 0; p < `ROUTER_PORTS; p++)
      begin
        refLen[p] = '0;
        refCount[p] = '0;
      end
    end
    else
    begin
      if (expGrant == 3'd0)
      begin
        for (int k = 0; k < `ROUTER_PORTS && nextGrant == 3'd0; k++)
          if (active[k])
            nextGrant = 3'(k + 1);
      end
      else if (active[holder] && refCount[holder] != limitOf(holder))
      begin
        nextGrant = expGrant;
        hold = 1'b1;
      end
      else
      begin
        // the holder is left out of the cyclic search.
        for (int k = 1; k < `ROUTER_PORTS && nextGrant == 3'd0; k++)
        begin
          idx = (holder + k) % `ROUTER_PORTS;
          if (active[idx])
            nextGrant = 3'(idx + 1);
        end
      end
      expValid = 1'b0;
      if (expGrant != 3'd0)
      begin
        if (req[holder])
        begin
          expValid = 1'b1;
          expData = flitData[holder];
        end
      end
      for (int p = 0; p < `ROUTER_PORTS; p++)
      begin
        refCount[p] = (hold && p == holder) ? refCount[p] + 12'd1 : '0;
        if (flitId[p] == `HEAD_ID)
          refLen[p] = pktLength[p];
      end
      if (cfgWrite && cfgSel == ADDR_MASK)
        refMask = cfgData[`ROUTER_PORTS-1:0];
      else if (cfgWrite && cfgSel == ADDR_CAP)
        refCap = cfgData;
      expGrant = nextGrant;
    end
  endtask

  task automatic checkOutputs();
    assert (grant === expGrant)
    else
    begin
      $display("error: %s grant expected %0d actual %0d", currentTest, expGrant, grant);
      endRun();
    end
    assert (outValid === expValid)
    else
    begin
      $display("error: %s outValid expected %0b actual %0b", currentTest, expValid, outValid);
      endRun();
    end
    assert (!expValid || outData === expData)
    else
    begin
      $display("error: %s outData expected %h actual %h", currentTest, expData, outData);
      endRun();
    end
  endtask

  // outputs are compared at the falling edge, well away from the inputs.
  task automatic stepCycle();
    @(negedge clk);
    if (!rst)
      checkOutputs();
    @(posedge clk);
    modelStep();
    #1;
  endtask

  task automatic drawWords();
    for (int p = 0; p < `ROUTER_PORTS; p++)
    begin
      lcgState = nextRandom(lcgState);
      flitData[p] = lcgState;
    end
  endtask

  task automatic runTest(input int t);
    currentTest = testName[t];
    // configuration goes in while all inputs are quiet.
    req = '0;
    for (int p = 0; p < `ROUTER_PORTS; p++)
      flitId[p] = BODY;
    cfgWrite = 1'b1;
    cfgSel = ADDR_MASK;
    cfgData = `LEN_W'(testMask[t]);
    drawWords();
    stepCycle();
    cfgSel = ADDR_CAP;
    cfgData = testCap[t];
    drawWords();
    stepCycle();
    cfgWrite = 1'b0;
    for (int c = 0; c < testCycles[t]; c++)
    begin
      req = testReq[t];
      for (int p = 0; p < `ROUTER_PORTS; p++)
      begin
        flitId[p] = (c == 0) ? HEAD : BODY;
        pktLength[p] = testLen[t][p];
      end
      drawWords();
      stepCycle();
    end
  endtask

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      endRun();
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    flitId = '0;
    pktLength = '0;
    flitData = '0;
    cfgWrite = 1'b0;
    cfgSel = ADDR_MASK;
    cfgData = '0;
    lcgState = 32'h62da;
    cycleCount = 0;
    tableSize = 0;
    currentTest = "reset";

    // lengths are listed S, W, E, N, L.
    addTest("idleAfterReset", 5'b11111, 12'hfff, 5'b00000, {5{12'd0}}, 6);
    addTest("loneRequester", 5'b11111, 12'hfff, 5'b00001, {48'd0, 12'd3}, 20);
    addTest("rotateAll", 5'b11111, 12'hfff, 5'b11111,
            {12'd1, 12'd3, 12'd0, 12'd2, 12'd1}, 40);
    addTest("northThenSouth", 5'b11111, 12'hfff, 5'b10010, {5{12'd2}}, 20);
    addTest("eastMasked", 5'b11011, 12'hfff, 5'b11111, {5{12'd1}}, 40);
    addTest("capShortens", 5'b11111, 12'd2, 5'b00100, {24'd0, 12'd9, 24'd0}, 20);
    addTest("capWithRotation", 5'b11111, 12'd1, 5'b11111, {5{12'd6}}, 30);

    cycleLimit = 100;
    for (int t = 0; t < tableSize; t++)
      cycleLimit += testCycles[t];

    repeat (RESET_CYCLES) stepCycle();
    rst = 1'b0;

    for (int t = 0; t < tableSize; t++)
      runTest(t);

    // drain the last registered output before the verdict.
    currentTest = "drain";
    req = '0;
    repeat (3) stepCycle();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: src.f
+incdir+logic
logic/routerPkg.sv
logic/arbConfig.sv
logic/grantTimer.sv
logic/outputArbiter.sv
logic/outputMux.sv
logic/routerOutputPort.sv
sim/routerOutputPortTb.sv
